// File: ofdm_payload_rx.f
ofdm_rx_pkg.sv
subcarrier_select.sv
symbol_demapper.sv
payload_buffer.sv
ofdm_payload_rx.sv
tb_ofdm_payload_rx.sv

// File: ofdm_payload_rx.sv
`timescale 1ns/1ps

module ofdm_payload_rx
    import ofdm_rx_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       sample_valid_i,
    input  iq_sample_t sample_i,
    input  mod_e       mod_i,
    input  logic       ready_i,
    output logic       byte_valid_o,
    output logic [7:0] byte_o,
    output logic       symbol_done_o
);

    logic          group_valid;
    sample_group_t group;
    logic          word_valid;
    group_word_t   word;

    // Done pulse also restarts the subcarrier index
    subcarrier_select subcarrier_select_inst (
        .clk            (clk),
        .reset          (reset),
        .sample_valid_i (sample_valid_i),
        .sample_i       (sample_i),
        .symbol_done_i  (symbol_done_o),
        .group_valid_o  (group_valid),
        .group_o        (group)
    );

    symbol_demapper symbol_demapper_inst (
        .clk           (clk),
        .reset         (reset),
        .mod_i         (mod_i),
        .group_valid_i (group_valid),
        .group_i       (group),
        .word_valid_o  (word_valid),
        .word_o        (word)
    );

    payload_buffer payload_buffer_inst (
        .clk           (clk),
        .reset         (reset),
        .word_valid_i  (word_valid),
        .word_i        (word),
        .ready_i       (ready_i),
        .byte_valid_o  (byte_valid_o),
        .byte_o        (byte_o),
        .symbol_done_o (symbol_done_o)
    );

endmodule

// File: ofdm_rx_pkg.sv
package ofdm_rx_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int SAMPLE_W        = 16;
    localparam int N_SUBCARRIERS   = 256;
    localparam int N_GROUP         = 8;
    localparam int N_GROUPS        = 24;
    localparam int MAX_GROUP_BYTES = 4;

    // Symbol buffer, sized for QAM16
    localparam int BUF_BYTES   = N_GROUPS * MAX_GROUP_BYTES;
    localparam int BYTE_ADDR_W = $clog2(BUF_BYTES);
    localparam int GROUP_CNT_W = $clog2(N_GROUPS + 1);
    localparam int IDX_W       = $clog2(N_SUBCARRIERS);
    localparam int SLOT_W      = $clog2(N_GROUP);

    //////////////////////////////
    // Subcarrier plan
    //////////////////////////////

    // Used band: 1..100 and 156..255, DC and guard 101..155 empty
    localparam logic [N_SUBCARRIERS-1:0] USED_MASK =
        {{100{1'b1}}, {55{1'b0}}, {100{1'b1}}, 1'b0};

    // Pilots at +-13, +-38, +-63, +-88
    localparam logic [N_SUBCARRIERS-1:0] PILOT_MASK =
        (N_SUBCARRIERS'(1) << 13)  |
        (N_SUBCARRIERS'(1) << 38)  |
        (N_SUBCARRIERS'(1) << 63)  |
        (N_SUBCARRIERS'(1) << 88)  |
        (N_SUBCARRIERS'(1) << 168) |
        (N_SUBCARRIERS'(1) << 193) |
        (N_SUBCARRIERS'(1) << 218) |
        (N_SUBCARRIERS'(1) << 243);

    // 192 data subcarriers remain
    localparam logic [N_SUBCARRIERS-1:0] DATA_MASK = USED_MASK & ~PILOT_MASK;

    //////////////////////////////
    // Modulation
    //////////////////////////////

    // Inner/outer decision level for QAM16
    localparam logic [SAMPLE_W-1:0] QAM16_THRESHOLD = 16'd8192;

    typedef enum logic [2:0]
    {
        MOD_BPSK  = 3'd0,
        MOD_QPSK  = 3'd1,
        MOD_QAM16 = 3'd2
    } mod_e;

    //////////////////////////////
    // Datapath words
    //////////////////////////////

    typedef struct packed
    {
        logic signed [SAMPLE_W-1:0] i;
        logic signed [SAMPLE_W-1:0] q;
    } iq_sample_t;

    typedef struct packed
    {
        iq_sample_t [N_GROUP-1:0] samples;
    } sample_group_t;

    // Demapped bits of one group, nbytes low bytes valid
    typedef struct packed
    {
        logic [8*MAX_GROUP_BYTES-1:0] bits;
        logic [2:0]                   nbytes;
    } group_word_t;

endpackage

// File: payload_buffer.sv
`timescale 1ns/1ps

module payload_buffer
    import ofdm_rx_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        word_valid_i,
    input  group_word_t word_i,
    input  logic        ready_i,
    output logic        byte_valid_o,
    output logic [7:0]  byte_o,
    output logic        symbol_done_o
);

    logic [7:0]             mem [BUF_BYTES];
    logic [GROUP_CNT_W-1:0] wr_count;
    logic [BYTE_ADDR_W-1:0] wr_base;
    logic [BYTE_ADDR_W-1:0] rd_ptr;
    logic [BYTE_ADDR_W-1:0] last_addr;
    logic [2:0]             sym_nbytes;
    logic                   wr_en;
    logic                   draining;
    logic                   finishing;

    assign wr_en     = word_valid_i && (wr_count < GROUP_CNT_W'(N_GROUPS));
    // Group g lands at byte g*nbytes
    assign wr_base   = BYTE_ADDR_W'(wr_count) * BYTE_ADDR_W'(word_i.nbytes);
    assign last_addr = BYTE_ADDR_W'(N_GROUPS * sym_nbytes - 1);

    //////////////////////////////
    // Fill and drain control
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_count      <= '0;
            rd_ptr        <= '0;
            sym_nbytes    <= '0;
            draining      <= 1'b0;
            finishing     <= 1'b0;
            byte_valid_o  <= 1'b0;
            symbol_done_o <= 1'b0;
        end
        else
        begin
            byte_valid_o  <= 1'b0;
            symbol_done_o <= finishing;
            finishing     <= 1'b0;

            if (wr_en)
            begin
                wr_count   <= wr_count + 1'b1;
                sym_nbytes <= word_i.nbytes;
                if (wr_count == GROUP_CNT_W'(N_GROUPS - 1))
                    draining <= 1'b1;
            end

            // Position held while ready is low
            if (draining && ready_i)
            begin
                byte_valid_o <= 1'b1;
                rd_ptr       <= rd_ptr + 1'b1;
                if (rd_ptr == last_addr)
                begin
                    draining  <= 1'b0;
                    finishing <= 1'b1;
                end
            end

            // Buffer empty for the next symbol
            if (finishing)
            begin
                wr_count <= '0;
                rd_ptr   <= '0;
            end
        end
    end

    //////////////////////////////
    // Byte storage
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            for (int b = 0; b < MAX_GROUP_BYTES; b++)
            begin
                if (b < int'(word_i.nbytes))
                    mem[wr_base + BYTE_ADDR_W'(b)] <= word_i.bits[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (draining && ready_i)
            byte_o <= mem[rd_ptr];
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the OFDM payload receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_ofdm_payload_rx \
    -f ofdm_payload_rx.f \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
    echo "Simulation reported failure, see $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0

// File: subcarrier_select.sv
`timescale 1ns/1ps

module subcarrier_select
    import ofdm_rx_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          sample_valid_i,
    input  iq_sample_t    sample_i,
    input  logic          symbol_done_i,
    output logic          group_valid_o,
    output sample_group_t group_o
);

    logic [IDX_W-1:0]  sc_index;
    logic [SLOT_W-1:0] slot;
    logic              sym_end;
    logic              take;

    // Data subcarrier present on this strobe
    assign take = sample_valid_i && !sym_end && DATA_MASK[sc_index];

    //////////////////////////////
    // Index and gather counters
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sc_index      <= '0;
            slot          <= '0;
            sym_end       <= 1'b0;
            group_valid_o <= 1'b0;
        end
        else
        begin
            group_valid_o <= 1'b0;
            if (symbol_done_i)
            begin
                sc_index <= '0;
                slot     <= '0;
                sym_end  <= 1'b0;
            end
            else if (sample_valid_i && !sym_end)
            begin
                // Index stops at the last subcarrier
                if (sc_index == IDX_W'(N_SUBCARRIERS - 1))
                    sym_end <= 1'b1;
                else
                    sc_index <= sc_index + 1'b1;

                if (take)
                begin
                    slot          <= slot + 1'b1;
                    group_valid_o <= (slot == SLOT_W'(N_GROUP - 1));
                end
            end
        end
    end

    // Gathered samples
    always_ff @(posedge clk)
    begin
        if (take)
            group_o.samples[slot] <= sample_i;
    end

endmodule

// File: symbol_demapper.sv
`timescale 1ns/1ps

module symbol_demapper
    import ofdm_rx_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  mod_e          mod_i,
    input  logic          group_valid_i,
    input  sample_group_t group_i,
    output logic          word_valid_o,
    output group_word_t   word_o
);

    group_word_t demap;

    // Outer point test, |v| >= threshold
    function automatic logic is_outer(input logic signed [SAMPLE_W-1:0] v);
        logic signed [SAMPLE_W:0] wide;
        logic signed [SAMPLE_W:0] th;
        wide = v;
        th   = $signed({1'b0, QAM16_THRESHOLD});
        return (wide >= th) || (wide <= -th);
    endfunction

    //////////////////////////////
    // Hard decisions
    //////////////////////////////

    always_comb
    begin
        demap.bits   = '0;
        demap.nbytes = 3'd1;
        for (int k = 0; k < N_GROUP; k++)
        begin
            case (mod_i)
                MOD_QPSK:
                begin
                    demap.bits[2*k]   = group_i.samples[k].i[SAMPLE_W-1];
                    demap.bits[2*k+1] = group_i.samples[k].q[SAMPLE_W-1];
                    demap.nbytes      = 3'd2;
                end
                MOD_QAM16:
                begin
                    demap.bits[4*k]   = group_i.samples[k].i[SAMPLE_W-1];
                    demap.bits[4*k+1] = is_outer(group_i.samples[k].i);
                    demap.bits[4*k+2] = group_i.samples[k].q[SAMPLE_W-1];
                    demap.bits[4*k+3] = is_outer(group_i.samples[k].q);
                    demap.nbytes      = 3'd4;
                end
                // BPSK, and any unknown code
                default:
                    demap.bits[k] = group_i.samples[k].i[SAMPLE_W-1];
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            word_valid_o <= 1'b0;
        else
            word_valid_o <= group_valid_i;
    end

    always_ff @(posedge clk)
    begin
        if (group_valid_i)
            word_o <= demap;
    end

endmodule

// File: tb_ofdm_payload_rx.sv
`timescale 1ns/1ps

module tb_ofdm_payload_rx
    import ofdm_rx_pkg::*;
();

    localparam int N_SYMBOLS   = 4;
    localparam int CYCLE_LIMIT = 16 + N_SYMBOLS * (256 + 96 + 200) + 100;
    localparam int OUTER_LEVEL = 8192;

    logic       clk;
    logic       reset;
    logic       sample_valid_i;
    iq_sample_t sample_i;
    mod_e       mod_i;
    logic       ready_i;
    logic       byte_valid_o;
    logic [7:0] byte_o;
    logic       symbol_done_o;

    logic [31:0] lfsr_state;
    logic [7:0]  exp_q[$];
    logic [7:0]  exp_byte;
    logic [7:0]  acc;
    int          nacc;
    int          exp_count;
    int          byte_count;
    int          cycles;
    logic        expect_ones;
    logic        done_seen;
    int          err_value;
    int          err_count;
    int          err_protocol;

    ofdm_payload_rx ofdm_payload_rx_inst (
        .clk            (clk),
        .reset          (reset),
        .sample_valid_i (sample_valid_i),
        .sample_i       (sample_i),
        .mod_i          (mod_i),
        .ready_i        (ready_i),
        .byte_valid_o   (byte_valid_o),
        .byte_o         (byte_o),
        .symbol_done_o  (symbol_done_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] lfsr_word16();
        logic [15:0] w;
        for (int n = 0; n < 16; n++)
            w[n] = lfsr_bit();
        return w;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Used band minus pilots
    function automatic logic is_data(input int idx);
        logic used;
        used = (idx >= 1 && idx <= 100) || (idx >= 156 && idx <= 255);
        case (idx)
            13, 38, 63, 88, 168, 193, 218, 243: return 1'b0;
            default: return used;
        endcase
    endfunction

    function automatic int bits_per_sc(input mod_e modulation);
        case (modulation)
            MOD_QPSK:  return 2;
            MOD_QAM16: return 4;
            default:   return 1;
        endcase
    endfunction

    function automatic logic outer_point(input logic signed [15:0] v);
        int mag;
        mag = v;
        if (mag < 0)
            mag = -mag;
        return mag >= OUTER_LEVEL;
    endfunction

    // Bits fill each byte from the LSB up
    task automatic append_bit(input logic b);
        acc[nacc] = b;
        nacc++;
        if (nacc == 8)
        begin
            exp_q.push_back(acc);
            acc  = '0;
            nacc = 0;
        end
    endtask

    task automatic model_sample(input mod_e modulation, input iq_sample_t s);
        append_bit(s.i[15]);
        if (modulation == MOD_QAM16)
            append_bit(outer_point(s.i));
        if (modulation != MOD_BPSK)
            append_bit(s.q[15]);
        if (modulation == MOD_QAM16)
            append_bit(outer_point(s.q));
    endtask

    // One full symbol followed by its drain up to the done pulse
    task automatic run_symbol(input mod_e modulation, input logic select_test,
                              input logic use_bp);
        iq_sample_t s;
        logic       data;
        mod_i       = modulation;
        expect_ones = select_test;
        exp_count   = 24 * bits_per_sc(modulation);
        for (int idx = 0; idx < 256; idx++)
        begin
            @(posedge clk);
            #2;
            s.i  = lfsr_word16();
            s.q  = lfsr_word16();
            data = is_data(idx);
            // Only data subcarriers negative in the selection test
            if (select_test)
                s.i[15] = data;
            sample_valid_i = 1'b1;
            sample_i       = s;
            ready_i        = use_bp ? lfsr_bit() : 1'b1;
            if (data)
                model_sample(modulation, s);
        end
        while (!done_seen)
        begin
            @(posedge clk);
            #2;
            sample_valid_i = 1'b0;
            ready_i        = use_bp ? lfsr_bit() : 1'b1;
        end
        done_seen = 1'b0;
    endtask

    //////////////////////////////
    // Checks
    //////////////////////////////

    always @(negedge clk)
    begin
        if (reset)
        begin
            assert (!byte_valid_o && !symbol_done_o)
            else
            begin
                err_protocol++;
                $display("ERR %0t: output active during reset", $time);
            end
        end
        else
        begin
            if (byte_valid_o)
            begin
                assert (exp_q.size() != 0)
                else
                begin
                    err_count++;
                    $display("ERR %0t: byte 0x%02h with nothing expected", $time, byte_o);
                end
                if (exp_q.size() != 0)
                begin
                    exp_byte = exp_q.pop_front();
                    assert (byte_o == exp_byte)
                    else
                    begin
                        err_value++;
                        $display("ERR %0t: byte 0x%02h, expected 0x%02h",
                                 $time, byte_o, exp_byte);
                    end
                end
                if (expect_ones)
                begin
                    assert (byte_o == 8'hff)
                    else
                    begin
                        err_value++;
                        $display("ERR %0t: non-data subcarrier leaked into byte 0x%02h",
                                 $time, byte_o);
                    end
                end
                byte_count++;
            end
            if (symbol_done_o)
            begin
                assert (byte_count == exp_count && exp_q.size() == 0)
                else
                begin
                    err_count++;
                    $display("ERR %0t: %0d bytes in symbol, expected %0d",
                             $time, byte_count, exp_count);
                end
                byte_count = 0;
                done_seen  = 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) byte_valid_o |-> $past(ready_i))
    else
    begin
        err_protocol++;
        $display("ERR %0t: byte issued after ready was low", $time);
    end

    assert property (@(posedge clk) disable iff (reset) symbol_done_o |-> !$past(symbol_done_o))
    else
    begin
        err_protocol++;
        $display("ERR %0t: symbol done held longer than one cycle", $time);
    end

    // Done only in the cycle after the final byte
    assert property (@(posedge clk) disable iff (reset) symbol_done_o |-> $past(byte_valid_o))
    else
    begin
        err_protocol++;
        $display("ERR %0t: symbol done without a final byte before it", $time);
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles == CYCLE_LIMIT)
        begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial
    begin
        reset          = 1'b1;
        sample_valid_i = 1'b0;
        sample_i       = '0;
        mod_i          = MOD_BPSK;
        ready_i        = 1'b0;
        lfsr_state     = 32'h3907_f93f;
        acc            = '0;
        nacc           = 0;
        exp_count      = 0;
        byte_count     = 0;
        cycles         = 0;
        expect_ones    = 1'b0;
        done_seen      = 1'b0;
        err_value      = 0;
        err_count      = 0;
        err_protocol   = 0;

        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (4) @(posedge clk);

        run_symbol(MOD_BPSK, 1'b1, 1'b0);
        run_symbol(MOD_BPSK, 1'b0, 1'b1);
        run_symbol(MOD_QPSK, 1'b0, 1'b1);
        run_symbol(MOD_QAM16, 1'b0, 1'b1);
        repeat (4) @(posedge clk);

        $display("errors: value %0d, count %0d, protocol %0d",
                 err_value, err_count, err_protocol);
        if (err_value + err_count + err_protocol == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule
